//--- rv64_decode_pipe.f
source/rv64_decode_pkg.sv
source/rv64_imm_extract.sv
source/rv64_classify_stage.sv
source/rv64_operand_stage.sv
source/rv64_decode_pipe.sv
verification/rv64_decode_pipe_tb.sv

//--- source/rv64_classify_stage.sv
`default_nettype none
`timescale 1ns/10ps

module rv64_classify_stage
#(
    parameter int ID_WIDTH = 8
)
(
    input  wire                              clk_i,
    input  wire                              arst_n_i,
    input  wire                              valid_i,
    input  wire rv64_decode_pkg::fetch_pkt_t pkt_i,
    input  wire [ID_WIDTH-1:0]               itag_i,
    output logic                             valid_o,
    output rv64_decode_pkg::fetch_pkt_t      pkt_o,
    output rv64_decode_pkg::class_t          class_o,
    output logic [ID_WIDTH-1:0]              itag_o
);

    rv64_decode_pkg::opcode_t   opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    rv64_decode_pkg::reg_idx_t  rs2_idx;
    rv64_decode_pkg::csr_addr_t csr_addr;
    logic                       fetch_fault;
    logic                       priv_op;
    logic                       csr_ok;
    rv64_decode_pkg::disp_t     disp_d;
    logic                       illegal_d;
    rv64_decode_pkg::class_t    class_d;

    assign opcode   = pkt_i.instr[6:2];
    assign funct3   = pkt_i.instr[14:12];
    assign funct7   = pkt_i.instr[31:25];
    assign rs2_idx  = pkt_i.instr[24:20];
    assign csr_addr = pkt_i.instr[31:20];

    assign fetch_fault = pkt_i.pageflt | pkt_i.accflt | pkt_i.addrmis;
    assign priv_op     = (opcode == rv64_decode_pkg::OP_SYSTEM) &&
                         (funct3 == rv64_decode_pkg::FUNCT3_PRIV);
    assign csr_ok      = pkt_i.priv >= csr_addr[9:8];  // csr[9:8] is the lowest privilege

    ////////////////////
    // dispatch and legality
    ////////////////////
    always_comb
    begin
        disp_d    = rv64_decode_pkg::DISP_NONE;
        illegal_d = 1'b1;                              // unknown unless matched
        if (fetch_fault)
        begin
            illegal_d = 1'b0;                          // fault is reported instead
        end
        else
        begin
            case (opcode)
                rv64_decode_pkg::OP_LOAD,
                rv64_decode_pkg::OP_STORE:
                begin
                    disp_d    = rv64_decode_pkg::DISP_LOADSTORE;
                    illegal_d = 1'b0;
                end
                rv64_decode_pkg::OP_MISCMEM:
                begin
                    disp_d    = rv64_decode_pkg::DISP_SYSMAG;
                    illegal_d = 1'b0;
                end
                rv64_decode_pkg::OP_OPIMM,
                rv64_decode_pkg::OP_OPIMM32,
                rv64_decode_pkg::OP_LUI:
                begin
                    disp_d    = rv64_decode_pkg::DISP_SHORTINT;
                    illegal_d = 1'b0;
                end
                rv64_decode_pkg::OP_OP,
                rv64_decode_pkg::OP_OP32:
                begin
                    disp_d    = (funct7 == rv64_decode_pkg::FUNCT7_MULDIV) ?
                                rv64_decode_pkg::DISP_MULDIV : rv64_decode_pkg::DISP_SHORTINT;
                    illegal_d = 1'b0;
                end
                rv64_decode_pkg::OP_AUIPC,
                rv64_decode_pkg::OP_BRANCH,
                rv64_decode_pkg::OP_JAL,
                rv64_decode_pkg::OP_JALR:
                begin
                    disp_d    = rv64_decode_pkg::DISP_BRANCH;
                    illegal_d = 1'b0;
                end
                rv64_decode_pkg::OP_SYSTEM:
                begin
                    if (priv_op)
                    begin
                        case (funct7)
                            rv64_decode_pkg::FUNCT7_ECALL: illegal_d = 1'b0;
                            rv64_decode_pkg::FUNCT7_SRET:  // wfi shares funct7, rs2 = 5
                                illegal_d = !((pkt_i.priv == rv64_decode_pkg::PRIV_SUPERVISOR) ||
                                              (rs2_idx == 5'd5));
                            rv64_decode_pkg::FUNCT7_MRET:
                                illegal_d = pkt_i.priv != rv64_decode_pkg::PRIV_MACHINE;
                            rv64_decode_pkg::FUNCT7_SFENCE:
                            begin
                                disp_d    = rv64_decode_pkg::DISP_SYSMAG;
                                illegal_d = 1'b0;
                            end
                            default:       illegal_d = 1'b1;
                        endcase
                    end
                    else if (csr_ok)
                    begin
                        disp_d    = rv64_decode_pkg::DISP_SHORTINT;  // csr ops run in the alu
                        illegal_d = 1'b0;
                    end
                end
                default:           illegal_d = 1'b1;  // fp, amo, reserved
            endcase
        end
    end

    assign class_d = '{
        disp:    disp_d,
        illegal: illegal_d,
        csr_en:  (opcode == rv64_decode_pkg::OP_SYSTEM) && !priv_op && csr_ok,
        mret:    !illegal_d && priv_op && (funct7 == rv64_decode_pkg::FUNCT7_MRET) &&
                 (rs2_idx == 5'd2),
        sret:    !illegal_d && priv_op && (funct7 == rv64_decode_pkg::FUNCT7_SRET) &&
                 (rs2_idx == 5'd2),
        ecall:   !illegal_d && priv_op && (funct7 == rv64_decode_pkg::FUNCT7_ECALL) &&
                 (rs2_idx == 5'd0),
        ebreak:  !illegal_d && priv_op && (funct7 == rv64_decode_pkg::FUNCT7_ECALL) &&
                 (rs2_idx == 5'd1),
        pageflt: pkt_i.pageflt,
        accflt:  pkt_i.accflt,
        addrmis: pkt_i.addrmis
    };

    ////////////////////
    // stage register
    ////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            valid_o <= 1'b0;
            pkt_o   <= '0;
            class_o <= '0;
            itag_o  <= '0;
        end
        else
        begin
            valid_o <= valid_i;
            if (valid_i)                               // hold through bubbles
            begin
                pkt_o   <= pkt_i;
                class_o <= class_d;
                itag_o  <= itag_i;
            end
        end
    end

    // an illegal instruction never leaves with a dispatch target
    illegal_no_disp_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o && class_o.illegal |-> (class_o.disp == rv64_decode_pkg::DISP_NONE));

endmodule

`default_nettype wire

//--- source/rv64_decode_pipe.sv
`default_nettype none
`timescale 1ns/10ps

module rv64_decode_pipe
#(
    parameter int ID_WIDTH = 8
)
(
    input  wire                               clk_i,
    input  wire                               arst_n_i,
    input  wire                               instr_valid_i,
    input  wire rv64_decode_pkg::instr_t      instr_i,
    input  wire rv64_decode_pkg::xlen_t       instr_pc_i,
    input  wire rv64_decode_pkg::priv_t       instr_priv_i,
    input  wire                               instr_pageflt_i,
    input  wire                               instr_accflt_i,
    input  wire                               instr_addrmis_i,
    input  wire [ID_WIDTH-1:0]                instr_id_i,
    output wire                               dec_valid_o,
    output wire rv64_decode_pkg::xlen_t       dec_pc_o,
    output wire [ID_WIDTH-1:0]                dec_itag_o,
    output wire rv64_decode_pkg::class_t      dec_class_o,
    output wire rv64_decode_pkg::operand_t    dec_ops_o
);

    logic                        s1_valid;
    rv64_decode_pkg::fetch_pkt_t s1_pkt;
    rv64_decode_pkg::class_t     s1_class;
    logic [ID_WIDTH-1:0]         s1_itag;

    rv64_classify_stage #(
        .ID_WIDTH (ID_WIDTH)
    ) rv64_classify_stage_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (instr_valid_i),
        .pkt_i    (rv64_decode_pkg::fetch_pkt_t'{
                       instr:   instr_i,
                       pc:      instr_pc_i,
                       priv:    instr_priv_i,
                       pageflt: instr_pageflt_i,
                       accflt:  instr_accflt_i,
                       addrmis: instr_addrmis_i}),
        .itag_i   (instr_id_i),
        .valid_o  (s1_valid),
        .pkt_o    (s1_pkt),
        .class_o  (s1_class),
        .itag_o   (s1_itag)
    );

    rv64_operand_stage #(
        .ID_WIDTH (ID_WIDTH)
    ) rv64_operand_stage_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (s1_valid),
        .pkt_i    (s1_pkt),
        .class_i  (s1_class),
        .itag_i   (s1_itag),
        .valid_o  (dec_valid_o),              // two cycles after instr_valid_i
        .pc_o     (dec_pc_o),
        .class_o  (dec_class_o),
        .ops_o    (dec_ops_o),
        .itag_o   (dec_itag_o)
    );

endmodule

`default_nettype wire

//--- source/rv64_decode_pkg.sv
`default_nettype none

package rv64_decode_pkg;

    ////////////////////
    // widths and scalar types
    ////////////////////
    localparam int XLEN = 64;

    typedef logic [31:0]     instr_t;
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [19:0]     imm_t;        // handed to execution as is
    typedef logic [9:0]      funct_t;      // {funct7, funct3}
    typedef logic [4:0]      opcode_t;     // instr[6:2]
    typedef logic [1:0]      priv_t;
    typedef logic [2:0]      disp_t;
    typedef logic [2:0]      brtype_t;     // return-address-stack hints

    ////////////////////
    // named codes
    ////////////////////
    localparam priv_t PRIV_USER       = 2'd0;
    localparam priv_t PRIV_SUPERVISOR = 2'd1;
    localparam priv_t PRIV_MACHINE    = 2'd3;

    localparam disp_t DISP_NONE      = 3'd0;
    localparam disp_t DISP_LOADSTORE = 3'd1;
    localparam disp_t DISP_SYSMAG    = 3'd2;  // fences and sfence.vma
    localparam disp_t DISP_SHORTINT  = 3'd3;
    localparam disp_t DISP_MULDIV    = 3'd4;
    localparam disp_t DISP_BRANCH    = 3'd5;

    localparam int BR_BIT_BRANCH = 0;
    localparam int BR_BIT_CALL   = 1;
    localparam int BR_BIT_RETURN = 2;

    localparam opcode_t OP_LOAD    = 5'b00000;
    localparam opcode_t OP_MISCMEM = 5'b00011;
    localparam opcode_t OP_OPIMM   = 5'b00100;
    localparam opcode_t OP_AUIPC   = 5'b00101;
    localparam opcode_t OP_OPIMM32 = 5'b00110;
    localparam opcode_t OP_STORE   = 5'b01000;
    localparam opcode_t OP_OP      = 5'b01100;
    localparam opcode_t OP_LUI     = 5'b01101;
    localparam opcode_t OP_OP32    = 5'b01110;
    localparam opcode_t OP_BRANCH  = 5'b11000;
    localparam opcode_t OP_JALR    = 5'b11001;
    localparam opcode_t OP_JAL     = 5'b11011;
    localparam opcode_t OP_SYSTEM  = 5'b11100;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
    localparam logic [2:0] FUNCT3_PRIV   = 3'b000;   // system ops that are not CSR ops
    localparam logic [6:0] FUNCT7_ECALL  = 7'b0000000; // ecall and ebreak
    localparam logic [6:0] FUNCT7_SRET   = 7'b0001000; // sret and wfi
    localparam logic [6:0] FUNCT7_MRET   = 7'b0011000;
    localparam logic [6:0] FUNCT7_SFENCE = 7'b0001001;

    ////////////////////
    // records between stages
    ////////////////////
    typedef struct packed {
        instr_t instr;
        xlen_t  pc;
        priv_t  priv;
        logic   pageflt;
        logic   accflt;
        logic   addrmis;
    } fetch_pkt_t;

    typedef struct packed {
        disp_t disp;
        logic  illegal;
        logic  csr_en;
        logic  mret;
        logic  sret;
        logic  ecall;
        logic  ebreak;
        logic  pageflt;
        logic  accflt;
        logic  addrmis;
    } class_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_idx_t  rs1_idx;
        reg_idx_t  rs2_idx;
        reg_idx_t  rd_idx;
        csr_addr_t csr_addr;
        logic      rs1_en;
        logic      rs2_en;
        logic      rd_en;
        funct_t    funct;
        imm_t      imm;
        brtype_t   brtype;
    } operand_t;

endpackage

`default_nettype wire

//--- source/rv64_imm_extract.sv
`default_nettype none
`timescale 1ns/10ps

module rv64_imm_extract
(
    input  wire rv64_decode_pkg::instr_t instr_i,
    output rv64_decode_pkg::imm_t        imm_o
);

    rv64_decode_pkg::opcode_t opcode;
    rv64_decode_pkg::imm_t    imm_i_type;
    rv64_decode_pkg::imm_t    imm_s_type;
    rv64_decode_pkg::imm_t    imm_b_type;
    rv64_decode_pkg::imm_t    imm_j_type;
    rv64_decode_pkg::imm_t    imm_u_type;
    rv64_decode_pkg::imm_t    imm_csr;

    assign opcode = instr_i[6:2];

    assign imm_i_type = {{8{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{8{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{8{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8]};  // offset[12:1]
    assign imm_j_type = {instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21]};                 // offset[20:1]
    assign imm_u_type = instr_i[31:12];
    assign imm_csr    = {15'b0, instr_i[19:15]};          // uimm of csrr*i

    always_comb
    begin
        case (opcode)
            rv64_decode_pkg::OP_OPIMM,
            rv64_decode_pkg::OP_OPIMM32,
            rv64_decode_pkg::OP_LOAD,
            rv64_decode_pkg::OP_JALR:   imm_o = imm_i_type;
            rv64_decode_pkg::OP_STORE:  imm_o = imm_s_type;
            rv64_decode_pkg::OP_BRANCH: imm_o = imm_b_type;
            rv64_decode_pkg::OP_JAL:    imm_o = imm_j_type;
            rv64_decode_pkg::OP_LUI,
            rv64_decode_pkg::OP_AUIPC:  imm_o = imm_u_type;
            rv64_decode_pkg::OP_SYSTEM: imm_o = imm_csr;
            default:                    imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/rv64_operand_stage.sv
`default_nettype none
`timescale 1ns/10ps

module rv64_operand_stage
#(
    parameter int ID_WIDTH = 8
)
(
    input  wire                              clk_i,
    input  wire                              arst_n_i,
    input  wire                              valid_i,
    input  wire rv64_decode_pkg::fetch_pkt_t pkt_i,
    input  wire rv64_decode_pkg::class_t     class_i,
    input  wire [ID_WIDTH-1:0]               itag_i,
    output logic                             valid_o,
    output rv64_decode_pkg::xlen_t           pc_o,
    output rv64_decode_pkg::class_t          class_o,
    output rv64_decode_pkg::operand_t        ops_o,
    output logic [ID_WIDTH-1:0]              itag_o
);

    rv64_decode_pkg::opcode_t  opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    rv64_decode_pkg::reg_idx_t rs1_idx;
    rv64_decode_pkg::reg_idx_t rd_idx;
    rv64_decode_pkg::funct_t   funct;
    logic                      rs1_en;
    logic                      rs2_en;
    logic                      rd_en;
    rv64_decode_pkg::imm_t     imm;
    logic                      rd_link;
    logic                      rs1_link;
    rv64_decode_pkg::brtype_t  brtype;
    rv64_decode_pkg::operand_t ops_d;

    assign opcode  = pkt_i.instr[6:2];
    assign funct3  = pkt_i.instr[14:12];
    assign funct7  = pkt_i.instr[31:25];
    assign rs1_idx = pkt_i.instr[19:15];
    assign rd_idx  = pkt_i.instr[11:7];

    rv64_imm_extract rv64_imm_extract_i
    (
        .instr_i (pkt_i.instr),
        .imm_o   (imm)
    );

    ////////////////////
    // funct and integer enables
    ////////////////////
    always_comb
    begin
        funct  = '0;
        rs1_en = 1'b0;
        rs2_en = 1'b0;
        rd_en  = 1'b0;
        case (opcode)
            rv64_decode_pkg::OP_LOAD:
            begin
                funct  = {7'b0, funct3};
                rs1_en = 1'b1;
                rd_en  = 1'b1;
            end
            rv64_decode_pkg::OP_STORE,
            rv64_decode_pkg::OP_BRANCH:
            begin
                funct  = {7'b0, funct3};
                rs1_en = 1'b1;
                rs2_en = 1'b1;
            end
            rv64_decode_pkg::OP_OP,
            rv64_decode_pkg::OP_OP32:
            begin
                funct  = {funct7, funct3};
                rs1_en = 1'b1;
                rs2_en = 1'b1;
                rd_en  = 1'b1;
            end
            rv64_decode_pkg::OP_OPIMM,
            rv64_decode_pkg::OP_OPIMM32:
            begin
                funct  = {funct7, funct3};             // funct7 tells srai from srli
                rs1_en = 1'b1;
                rd_en  = 1'b1;
            end
            rv64_decode_pkg::OP_LUI,
            rv64_decode_pkg::OP_AUIPC,
            rv64_decode_pkg::OP_JAL:   rd_en = 1'b1;
            rv64_decode_pkg::OP_JALR:
            begin
                funct  = {7'b0, funct3};
                rs1_en = 1'b1;
                rd_en  = 1'b1;
            end
            rv64_decode_pkg::OP_SYSTEM:
            begin
                if (funct3 != rv64_decode_pkg::FUNCT3_PRIV)
                begin
                    funct  = {7'b0, funct3};           // csr op
                    rs1_en = 1'b1;
                    rd_en  = 1'b1;
                end
                else
                begin
                    funct = {funct7, funct3};
                end
            end
            rv64_decode_pkg::OP_MISCMEM: funct = {funct7, funct3};
            default:                     funct = '0;
        endcase
    end

    // return-address-stack hints, x1 and x5 are link registers
    assign rd_link  = (rd_idx == 5'd1) || (rd_idx == 5'd5);
    assign rs1_link = (rs1_idx == 5'd1) || (rs1_idx == 5'd5);

    assign brtype[rv64_decode_pkg::BR_BIT_BRANCH] = (opcode == rv64_decode_pkg::OP_BRANCH) ||
                                                    (opcode == rv64_decode_pkg::OP_JAL);
    assign brtype[rv64_decode_pkg::BR_BIT_CALL]   = ((opcode == rv64_decode_pkg::OP_JAL) ||
                                                     (opcode == rv64_decode_pkg::OP_JALR)) &&
                                                    rd_link;
    assign brtype[rv64_decode_pkg::BR_BIT_RETURN] = (opcode == rv64_decode_pkg::OP_JALR) &&
                                                    rs1_link &&
                                                    !(rd_link && (rd_idx == rs1_idx));

    assign ops_d = '{
        opcode:   opcode,
        rs1_idx:  rs1_idx,
        rs2_idx:  pkt_i.instr[24:20],
        rd_idx:   rd_idx,
        csr_addr: pkt_i.instr[31:20],
        rs1_en:   rs1_en,
        rs2_en:   rs2_en,
        rd_en:    rd_en,
        funct:    funct,
        imm:      imm,
        brtype:   brtype
    };

    ////////////////////
    // stage register
    ////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            valid_o <= 1'b0;
            pc_o    <= '0;
            class_o <= '0;
            ops_o   <= '0;
            itag_o  <= '0;
        end
        else
        begin
            valid_o <= valid_i;
            if (valid_i)
            begin
                pc_o    <= pkt_i.pc;
                class_o <= class_i;                    // classify result rides along
                ops_o   <= ops_d;
                itag_o  <= itag_i;
            end
        end
    end

    // the strobe must stay clean once the whole pipe is out of reset
    valid_known_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown(valid_o));

endmodule

`default_nettype wire

//--- verification/rv64_decode_pipe_tb.sv
`default_nettype none
`timescale 1ns/10ps

module rv64_decode_pipe_tb;

    localparam int ID_WIDTH  = 8;
    localparam int MAX_TESTS = 256;
    localparam int LATENCY   = 2;

    typedef logic [ID_WIDTH-1:0] tag_t;

    logic                        clk = 1'b0;
    logic                        arst_n;
    logic                        instr_valid;
    rv64_decode_pkg::instr_t     instr;
    rv64_decode_pkg::xlen_t      instr_pc;
    rv64_decode_pkg::priv_t      instr_priv;
    logic                        instr_pageflt;
    logic                        instr_accflt;
    logic                        instr_addrmis;
    tag_t                        instr_id;
    logic                        dec_valid;
    rv64_decode_pkg::xlen_t      dec_pc;
    tag_t                        dec_itag;
    rv64_decode_pkg::class_t     dec_class;
    rv64_decode_pkg::operand_t   dec_ops;

    string                       test_name [MAX_TESTS];
    rv64_decode_pkg::fetch_pkt_t test_pkt  [MAX_TESTS];
    tag_t                        test_tag  [MAX_TESTS];
    rv64_decode_pkg::class_t     exp_class [MAX_TESTS];
    rv64_decode_pkg::operand_t   exp_ops   [MAX_TESTS];
    int                          num_tests    = 0;
    int                          pend_idx_q   [$];   // tests in flight, oldest first
    int                          pend_cycle_q [$];   // cycle each one was driven in
    int                          cycle        = 0;
    int                          cycle_limit  = 1000;
    int                          mismatch_cnt = 0;
    int                          other_cnt    = 0;
    int                          checked_cnt  = 0;
    int                          chk_idx;
    int                          chk_cycle;
    logic [15:0]                 lfsr_state;

    always #4 clk = ~clk;                             // 8 ns period

    rv64_decode_pipe #(
        .ID_WIDTH (ID_WIDTH)
    ) rv64_decode_pipe_i (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .instr_valid_i   (instr_valid),
        .instr_i         (instr),
        .instr_pc_i      (instr_pc),
        .instr_priv_i    (instr_priv),
        .instr_pageflt_i (instr_pageflt),
        .instr_accflt_i  (instr_accflt),
        .instr_addrmis_i (instr_addrmis),
        .instr_id_i      (instr_id),
        .dec_valid_o     (dec_valid),
        .dec_pc_o        (dec_pc),
        .dec_itag_o      (dec_itag),
        .dec_class_o     (dec_class),
        .dec_ops_o       (dec_ops)
    );

    ////////////////////
    // helpers
    ////////////////////
    function automatic logic next_rand_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit)
        begin
            lfsr_state = lfsr_state ^ 16'hB400;      // galois taps 16,14,13,11
        end
        return out_bit;
    endfunction

    task automatic check_class(input string name, input rv64_decode_pkg::class_t exp_v,
                               input rv64_decode_pkg::class_t act_v);
        if (act_v !== exp_v)
        begin
            mismatch_cnt++;
            $display("Mismatch %s class: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_ops(input string name, input rv64_decode_pkg::operand_t exp_v,
                             input rv64_decode_pkg::operand_t act_v);
        if (act_v !== exp_v)
        begin
            mismatch_cnt++;
            $display("Mismatch %s operands: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_pc(input string name, input rv64_decode_pkg::xlen_t exp_v,
                            input rv64_decode_pkg::xlen_t act_v);
        if (act_v !== exp_v)
        begin
            mismatch_cnt++;
            $display("Mismatch %s pc: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp_v, input tag_t act_v);
        if (act_v !== exp_v)
        begin
            mismatch_cnt++;
            $display("Mismatch %s tag: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic load_tests();
        int                          fd;
        int                          n_fields;
        string                       line;
        string                       name;
        logic [63:0]                 fld [13];
        rv64_decode_pkg::fetch_pkt_t pkt;
        rv64_decode_pkg::class_t     cls;
        rv64_decode_pkg::operand_t   ops;
        fd = $fopen("verification/rv64_decode_tests.txt", "r");
        if (fd == 0)
        begin
            other_cnt++;
            $display("could not open the test vector file");
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS)
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
            begin
                continue;                            // blank or column notes
            end
            n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                               fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                               fld[7], fld[8], fld[9], fld[10], fld[11], fld[12]);
            if (n_fields != 14)
            begin
                other_cnt++;
                $display("malformed line in the test vector file: %s", line);
                continue;
            end
            pkt.instr   = fld[0][31:0];
            pkt.pc      = fld[1];
            pkt.priv    = fld[2][1:0];
            pkt.pageflt = fld[3][2];
            pkt.accflt  = fld[3][1];
            pkt.addrmis = fld[3][0];
            // fault flags and instruction fields pass straight through
            cls.disp    = fld[5][2:0];
            cls.illegal = fld[6][0];
            cls.csr_en  = fld[7][0];
            cls.mret    = fld[8][3];
            cls.sret    = fld[8][2];
            cls.ecall   = fld[8][1];
            cls.ebreak  = fld[8][0];
            cls.pageflt = fld[3][2];
            cls.accflt  = fld[3][1];
            cls.addrmis = fld[3][0];
            ops.opcode   = pkt.instr[6:2];
            ops.rs1_idx  = pkt.instr[19:15];
            ops.rs2_idx  = pkt.instr[24:20];
            ops.rd_idx   = pkt.instr[11:7];
            ops.csr_addr = pkt.instr[31:20];
            ops.rs1_en   = fld[9][2];
            ops.rs2_en   = fld[9][1];
            ops.rd_en    = fld[9][0];
            ops.funct    = fld[10][9:0];
            ops.imm      = fld[11][19:0];
            ops.brtype   = fld[12][2:0];
            test_name[num_tests] = name;
            test_pkt[num_tests]  = pkt;
            test_tag[num_tests]  = fld[4][ID_WIDTH-1:0];
            exp_class[num_tests] = cls;
            exp_ops[num_tests]   = ops;
            num_tests++;
        end
        $fclose(fd);
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d tests checked",
                 mismatch_cnt, other_cnt, checked_cnt, num_tests);
    endtask

    ////////////////////
    // stimulus
    ////////////////////
    initial
    begin
        lfsr_state    = 16'd4;
        arst_n        = 1'b0;
        instr_valid   = 1'b1;                        // reset has to mask the strobe
        instr         = '0;
        instr_pc      = '0;
        instr_priv    = rv64_decode_pkg::PRIV_MACHINE;
        instr_pageflt = 1'b0;
        instr_accflt  = 1'b0;
        instr_addrmis = 1'b0;
        instr_id      = '0;
        load_tests();
        cycle_limit = 2 * num_tests + 20;            // one bubble per test at most
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (int i = 0; i < num_tests; i++)
        begin
            if ({next_rand_bit(), next_rand_bit()} == 2'b00)
            begin
                instr_valid = 1'b0;                  // bubble
                @(posedge clk);
                #1;
            end
            instr         = test_pkt[i].instr;
            instr_pc      = test_pkt[i].pc;
            instr_priv    = test_pkt[i].priv;
            instr_pageflt = test_pkt[i].pageflt;
            instr_accflt  = test_pkt[i].accflt;
            instr_addrmis = test_pkt[i].addrmis;
            instr_id      = test_tag[i];
            instr_valid   = 1'b1;
            pend_idx_q.push_back(i);
            pend_cycle_q.push_back(cycle);
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b0;
        while (pend_idx_q.size() != 0)
        begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);                   // catch stray strobes
        if (checked_cnt != num_tests)
        begin
            other_cnt++;
            $display("only %0d of %0d tests reached the output", checked_cnt, num_tests);
        end
        report_counts();
        if (mismatch_cnt == 0 && other_cnt == 0 && num_tests > 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

    ////////////////////
    // checking
    ////////////////////
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle >= cycle_limit)
        begin
            $display("timeout after %0d cycles, %0d tests never came out",
                     cycle, pend_idx_q.size());
            report_counts();
            $display("TEST FAIL");
            $finish;
        end
    end

    always @(negedge clk)                             // outputs settled mid-cycle
    begin
        if (!arst_n && dec_valid !== 1'b0)
        begin
            other_cnt++;
            $display("output strobe seen during reset");
        end
        else if (arst_n && dec_valid === 1'b1)
        begin
            if (pend_idx_q.size() == 0)
            begin
                other_cnt++;
                $display("output strobe at cycle %0d with no instruction in flight", cycle);
            end
            else
            begin
                chk_idx   = pend_idx_q.pop_front();
                chk_cycle = pend_cycle_q.pop_front();
                checked_cnt++;
                if (cycle != chk_cycle + LATENCY)
                begin
                    other_cnt++;
                    $display("test %s came out %0d cycles after its input instead of %0d",
                             test_name[chk_idx], cycle - chk_cycle, LATENCY);
                end
                check_class(test_name[chk_idx], exp_class[chk_idx], dec_class);
                check_ops(test_name[chk_idx], exp_ops[chk_idx], dec_ops);
                check_pc(test_name[chk_idx], test_pkt[chk_idx].pc, dec_pc);
                check_tag(test_name[chk_idx], test_tag[chk_idx], dec_itag);
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/rv64_decode_tests.txt
# name instr pc priv flt tag | expected: disp ill csr ev en funct imm br (all hex)
# flt = {pageflt,accflt,addrmis}  ev = {mret,sret,ecall,ebreak}  en = {rs1,rs2,rd}
# opcode, register indices and csr address are taken from the instruction fields
ld_pos       00813283 1000 3 0 01  1 0 0 0 5 003 00008 0
lw_neg       ffc52303 1004 3 0 02  1 0 0 0 5 002 ffffc 0
lbu_max      7ff14083 1008 0 0 03  1 0 0 0 5 004 007ff 0
sd_pos       00713823 100c 3 0 04  1 0 0 0 6 003 00010 0
sw_neg       fe84ac23 1010 1 0 05  1 0 0 0 6 002 ffff8 0
addi_neg     fff00093 1014 3 0 06  3 0 0 0 5 3f8 fffff 0
srai         40335293 1018 3 0 07  3 0 0 0 5 105 00403 0
addiw        0015051b 101c 0 0 08  3 0 0 0 5 000 00001 0
lui          123451b7 1020 3 0 09  3 0 0 0 1 000 12345 0
add          002081b3 1024 3 0 0a  3 0 0 0 7 000 00000 0
sub          40628233 1028 3 0 0b  3 0 0 0 7 100 00000 0
mul          029403b3 102c 3 0 0c  4 0 0 0 7 008 00000 0
divw         027342bb 1030 0 0 0d  4 0 0 0 7 00c 00000 0
auipc        fffff097 ffffffff80000000 3 0 0e  5 0 0 0 1 000 fffff 0
beq_fwd      00208863 1038 3 0 0f  5 0 0 0 6 000 00008 1
bne_back     fe019ee3 103c 3 0 10  5 0 0 0 6 001 ffffe 1
jal_call     001000ef 1040 3 0 11  5 0 0 0 1 000 00400 3
jal_back     ff9ff06f 1044 3 0 12  5 0 0 0 1 000 ffffc 1
jalr_ret     00008067 1048 3 0 13  5 0 0 0 5 000 00000 4
jalr_x5_x1   000082e7 104c 3 0 14  5 0 0 0 5 000 00000 6
jalr_x1_x1   000080e7 1050 3 0 15  5 0 0 0 5 000 00000 2
jalr_off     00c300e7 1054 3 0 16  5 0 0 0 5 000 0000c 2
fence        0ff0000f 1058 0 0 17  2 0 0 0 0 038 00000 0
sfence_vma   12b50073 105c 1 0 18  2 0 0 0 0 048 0000a 0
mret_m       30200073 1060 3 0 19  0 0 0 8 0 0c0 00000 0
mret_u       30200073 1064 0 0 1a  0 1 0 0 0 0c0 00000 0
sret_s       10200073 1068 1 0 1b  0 0 0 4 0 040 00000 0
sret_m       10200073 106c 3 0 1c  0 1 0 0 0 040 00000 0
wfi_u        10500073 1070 0 0 1d  0 0 0 0 0 040 00000 0
ecall        00000073 1074 0 0 1e  0 0 0 2 0 000 00000 0
ebreak       00100073 1078 3 0 1f  0 0 0 1 0 000 00000 0
priv_bad     fe000073 107c 3 0 20  0 1 0 0 0 3f8 00000 0
csr_m_from_s 300022f3 1080 1 0 21  0 1 0 0 5 002 00000 0
csr_m_from_m 300022f3 1084 3 0 22  3 0 1 0 5 002 00000 0
csr_s_imm    1002d073 1088 1 0 23  3 0 1 0 5 005 00005 0
csr_u_cycle  c00020f3 108c 0 0 24  3 0 1 0 5 002 00000 0
fadd_d       023170d3 1090 3 0 25  0 1 0 0 0 000 00000 0
fld          00013087 1094 3 0 26  0 1 0 0 0 000 00000 0
amoadd_d     0063b2af 1098 3 0 27  0 1 0 0 0 000 00000 0
undef_accflt ffffffff 109c 3 2 28  0 0 0 0 0 000 00000 0
fadd_addrmis 023170d3 10a0 3 1 29  0 0 0 0 0 000 00000 0
add_pageflt  002081b3 10a4 3 4 2a  0 0 0 0 7 000 00000 0
